// ==== source/snake_defs.svh ====
`ifndef SNAKE_DEFS_SVH
`define SNAKE_DEFS_SVH

// Segments on one digit, A through G
`define SNAKE_SEG_COUNT 7

// Default tick periods in clock cycles, for a 100 MHz board clock
`define SNAKE_SAMPLE_DIV 100000
`define SNAKE_SEC_DIV 100000000
`define SNAKE_HALF_DIV 50000000

// Second ticks spent showing G before play starts
`define SNAKE_INIT_HOLD 3

// Half-second ticks to linger on a full trail
`define SNAKE_FALL_HOLD 1

// Consecutive high samples before a button counts as pressed
`define SNAKE_DEBOUNCE_DEPTH 4

`endif

// ==== source/snake_pkg.sv ====
`include "snake_defs.svh"

package snake_pkg;

    // Active low, bit 0 is A and bit 6 is G
    typedef logic [`SNAKE_SEG_COUNT-1:0] seg_vec_t;

    // Index 0 right, 1 left, 2 up, 3 down
    typedef logic [3:0] btn_vec_t;

    typedef enum logic [2:0] {
        SEG_A,
        SEG_B,
        SEG_C,
        SEG_D,
        SEG_E,
        SEG_F,
        SEG_G
    } seg_id_t;

    typedef enum logic [1:0] {
        HEAD_RIGHT,
        HEAD_LEFT,
        HEAD_UP,
        HEAD_DOWN
    } heading_t;

    typedef enum logic [1:0] {
        MODE_INIT,
        MODE_MOVE,
        MODE_FALL
    } mode_t;

endpackage

// ==== source/tick_gen.sv ====
`include "snake_defs.svh"

module tick_gen #(
    parameter int SAMPLE_DIV = `SNAKE_SAMPLE_DIV,
    parameter int SEC_DIV = `SNAKE_SEC_DIV,
    parameter int HALF_DIV = `SNAKE_HALF_DIV
) (
    input  logic clk,
    input  logic rst,
    output logic sample_tick,
    output logic sec_tick,
    output logic half_tick
);

    function automatic int max_of(input int a, input int b);
        return (a > b) ? a : b;
    endfunction

    localparam int NUM_DIV = 3;
    localparam int DIV [NUM_DIV] = '{SAMPLE_DIV, SEC_DIV, HALF_DIV};
    localparam int CNT_W = $clog2(max_of(max_of(SAMPLE_DIV, SEC_DIV), HALF_DIV));

    logic [NUM_DIV-1:0] ticks;

    // One wrap-around counter per period, pulse on the wrap
    for (genvar i = 0; i < NUM_DIV; i++) begin : g_div
        logic [CNT_W-1:0] count_q;
        logic tick_q;

        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                count_q <= '0;
                tick_q <= 1'b0;
            end else if (count_q == CNT_W'(DIV[i] - 1)) begin
                count_q <= '0;
                tick_q <= 1'b1;
            end else begin
                count_q <= count_q + 1'b1;
                tick_q <= 1'b0;
            end
        end

        assign ticks[i] = tick_q;
    end

    assign sample_tick = ticks[0];
    assign sec_tick = ticks[1];
    assign half_tick = ticks[2];

endmodule

// ==== source/button_conditioner.sv ====
`include "snake_defs.svh"

module button_conditioner (
    input  logic                clk,
    input  logic                rst,
    input  logic                sample_tick,
    input  snake_pkg::btn_vec_t buttons,
    output snake_pkg::btn_vec_t btn_pulse
);

    localparam int NUM_BTN = $bits(snake_pkg::btn_vec_t);
    localparam int DEPTH = `SNAKE_DEBOUNCE_DEPTH;

    logic [DEPTH-1:0] shift_q [NUM_BTN];
    snake_pkg::btn_vec_t level;
    snake_pkg::btn_vec_t level_q;

    // Sample history, advanced once per sample tick
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_BTN; i++) begin
                shift_q[i] <= '0;
            end
        end else if (sample_tick) begin
            for (int i = 0; i < NUM_BTN; i++) begin
                shift_q[i] <= {shift_q[i][DEPTH-2:0], buttons[i]};
            end
        end
    end

    // Debounced only when every stored sample is high
    always_comb begin
        for (int i = 0; i < NUM_BTN; i++) begin
            level[i] = &shift_q[i];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            level_q <= '0;
            btn_pulse <= '0;
        end else begin
            level_q <= level;
            btn_pulse <= level & ~level_q;
        end
    end

endmodule

// ==== source/mode_fsm.sv ====
`include "snake_defs.svh"

module mode_fsm (
    input  logic             clk,
    input  logic             rst,
    input  logic             sec_tick,
    input  logic             half_tick,
    input  logic             down_pulse,
    input  logic             trail_full,
    output snake_pkg::mode_t mode,
    output logic             init,
    output logic             move,
    output logic             fall
);

    localparam int HOLD_MAX = (`SNAKE_INIT_HOLD > `SNAKE_FALL_HOLD) ?
                              `SNAKE_INIT_HOLD : `SNAKE_FALL_HOLD;
    localparam int HOLD_W = $clog2(HOLD_MAX + 1);

    snake_pkg::mode_t mode_q;
    logic [HOLD_W-1:0] hold_q;

    // Hold counter restarts from zero on every mode change
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mode_q <= snake_pkg::MODE_INIT;
            hold_q <= '0;
        end else begin
            case (mode_q)
                snake_pkg::MODE_INIT: begin
                    if (sec_tick) begin
                        if (hold_q == HOLD_W'(`SNAKE_INIT_HOLD - 1)) begin
                            mode_q <= snake_pkg::MODE_MOVE;
                            hold_q <= '0;
                        end else begin
                            hold_q <= hold_q + 1'b1;
                        end
                    end
                end
                snake_pkg::MODE_MOVE: begin
                    if (down_pulse) begin
                        mode_q <= snake_pkg::MODE_FALL;
                        hold_q <= '0;
                    end
                end
                snake_pkg::MODE_FALL: begin
                    // Linger only once the whole digit is lit
                    if (trail_full && half_tick) begin
                        if (hold_q == HOLD_W'(`SNAKE_FALL_HOLD - 1)) begin
                            mode_q <= snake_pkg::MODE_INIT;
                            hold_q <= '0;
                        end else begin
                            hold_q <= hold_q + 1'b1;
                        end
                    end
                end
                default: begin
                    mode_q <= snake_pkg::MODE_INIT;
                    hold_q <= '0;
                end
            endcase
        end
    end

    assign mode = mode_q;
    assign init = (mode_q == snake_pkg::MODE_INIT);
    assign move = (mode_q == snake_pkg::MODE_MOVE);
    assign fall = (mode_q == snake_pkg::MODE_FALL);

endmodule

// ==== source/segment_walker.sv ====
module segment_walker (
    input  logic                clk,
    input  logic                rst,
    input  snake_pkg::mode_t    mode,
    input  snake_pkg::btn_vec_t btn_pulse,
    output snake_pkg::seg_id_t  cur_seg,
    output snake_pkg::heading_t heading
);

    snake_pkg::seg_id_t seg_q;
    snake_pkg::seg_id_t next_seg;
    snake_pkg::heading_t head_q;
    snake_pkg::heading_t next_head;
    logic right;
    logic left;
    logic up;

    assign right = btn_pulse[0];
    assign left = btn_pulse[1];
    assign up = btn_pulse[2];

    // Walk table, earlier entries take priority on simultaneous pulses
    always_comb begin
        next_seg = seg_q;
        next_head = head_q;
        case (seg_q)
            snake_pkg::SEG_A: begin
                if (head_q == snake_pkg::HEAD_RIGHT && right) begin
                    next_seg = snake_pkg::SEG_B;
                    next_head = snake_pkg::HEAD_DOWN;
                end else if (head_q == snake_pkg::HEAD_LEFT && left) begin
                    next_seg = snake_pkg::SEG_F;
                    next_head = snake_pkg::HEAD_DOWN;
                end
            end
            snake_pkg::SEG_B: begin
                if (head_q == snake_pkg::HEAD_UP && left) begin
                    next_seg = snake_pkg::SEG_A;
                    next_head = snake_pkg::HEAD_LEFT;
                end else if (head_q == snake_pkg::HEAD_DOWN && right) begin
                    next_seg = snake_pkg::SEG_G;
                    next_head = snake_pkg::HEAD_LEFT;
                end else if (head_q == snake_pkg::HEAD_DOWN && up) begin
                    next_seg = snake_pkg::SEG_C;
                    next_head = snake_pkg::HEAD_DOWN;
                end
            end
            snake_pkg::SEG_C: begin
                if (head_q == snake_pkg::HEAD_UP && left) begin
                    next_seg = snake_pkg::SEG_G;
                    next_head = snake_pkg::HEAD_LEFT;
                end else if (head_q == snake_pkg::HEAD_UP && up) begin
                    next_seg = snake_pkg::SEG_B;
                    next_head = snake_pkg::HEAD_UP;
                end else if (head_q == snake_pkg::HEAD_DOWN && right) begin
                    next_seg = snake_pkg::SEG_D;
                    next_head = snake_pkg::HEAD_DOWN;
                end
            end
            snake_pkg::SEG_D: begin
                if (head_q == snake_pkg::HEAD_RIGHT && left) begin
                    next_seg = snake_pkg::SEG_C;
                    next_head = snake_pkg::HEAD_UP;
                end else if (head_q == snake_pkg::HEAD_LEFT && right) begin
                    next_seg = snake_pkg::SEG_E;
                    next_head = snake_pkg::HEAD_UP;
                end
            end
            snake_pkg::SEG_E: begin
                if (head_q == snake_pkg::HEAD_UP && right) begin
                    next_seg = snake_pkg::SEG_G;
                    next_head = snake_pkg::HEAD_RIGHT;
                end else if (head_q == snake_pkg::HEAD_UP && up) begin
                    next_seg = snake_pkg::SEG_F;
                    next_head = snake_pkg::HEAD_UP;
                end else if (head_q == snake_pkg::HEAD_DOWN && left) begin
                    next_seg = snake_pkg::SEG_D;
                    next_head = snake_pkg::HEAD_RIGHT;
                end
            end
            snake_pkg::SEG_F: begin
                if (head_q == snake_pkg::HEAD_UP && right) begin
                    next_seg = snake_pkg::SEG_A;
                    next_head = snake_pkg::HEAD_RIGHT;
                end else if (head_q == snake_pkg::HEAD_DOWN && left) begin
                    next_seg = snake_pkg::SEG_G;
                    next_head = snake_pkg::HEAD_RIGHT;
                end
            end
            snake_pkg::SEG_G: begin
                if (head_q == snake_pkg::HEAD_RIGHT && left) begin
                    next_seg = snake_pkg::SEG_B;
                    next_head = snake_pkg::HEAD_UP;
                end else if (head_q == snake_pkg::HEAD_RIGHT && right) begin
                    next_seg = snake_pkg::SEG_C;
                    next_head = snake_pkg::HEAD_DOWN;
                end else if (head_q == snake_pkg::HEAD_LEFT && left) begin
                    next_seg = snake_pkg::SEG_E;
                    next_head = snake_pkg::HEAD_DOWN;
                end else if (head_q == snake_pkg::HEAD_LEFT && right) begin
                    next_seg = snake_pkg::SEG_F;
                    next_head = snake_pkg::HEAD_UP;
                end
            end
            default: begin
                next_seg = snake_pkg::SEG_G;
                next_head = snake_pkg::HEAD_LEFT;
            end
        endcase
    end

    // Parked on G heading left until play starts
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            seg_q <= snake_pkg::SEG_G;
            head_q <= snake_pkg::HEAD_LEFT;
        end else if (mode == snake_pkg::MODE_INIT) begin
            seg_q <= snake_pkg::SEG_G;
            head_q <= snake_pkg::HEAD_LEFT;
        end else begin
            seg_q <= next_seg;
            head_q <= next_head;
        end
    end

    assign cur_seg = seg_q;
    assign heading = head_q;

endmodule

// ==== source/trail_display.sv ====
`include "snake_defs.svh"

module trail_display (
    input  logic                clk,
    input  logic                rst,
    input  snake_pkg::mode_t    mode,
    input  snake_pkg::seg_id_t  cur_seg,
    input  logic                half_tick,
    output snake_pkg::seg_vec_t display,
    output logic                trail_full
);

    localparam int N = `SNAKE_SEG_COUNT;

    // Trail record is active high, one bit per visited segment
    logic [N-1:0] record_q;
    logic [N-1:0] cur_mask;
    logic [N-1:0] trail_next;
    logic [N-1:0] lit;
    logic blink_q;

    assign cur_mask = N'(1) << cur_seg;
    assign trail_next = record_q | cur_mask;

    always_comb begin
        case (mode)
            snake_pkg::MODE_INIT: lit = N'(1) << snake_pkg::SEG_G;
            snake_pkg::MODE_MOVE: lit = cur_mask;
            // Head goes dark during the set blink phase
            default: lit = blink_q ? (trail_next ^ cur_mask) : trail_next;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            record_q <= '0;
            blink_q <= 1'b0;
            display <= ~(N'(1) << snake_pkg::SEG_G);
        end else begin
            if (half_tick) begin
                blink_q <= ~blink_q;
            end
            record_q <= (mode == snake_pkg::MODE_FALL) ? trail_next : '0;
            display <= ~lit;
        end
    end

    assign trail_full = &record_q;

endmodule

// ==== source/segment_snake.sv ====
`include "snake_defs.svh"

module segment_snake #(
    parameter int SAMPLE_DIV = `SNAKE_SAMPLE_DIV,
    parameter int SEC_DIV = `SNAKE_SEC_DIV,
    parameter int HALF_DIV = `SNAKE_HALF_DIV
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                right,
    input  logic                left,
    input  logic                up,
    input  logic                down,
    output snake_pkg::seg_vec_t display,
    output logic                init,
    output logic                move,
    output logic                fall,
    output snake_pkg::heading_t pos
);

    logic sample_tick;
    logic sec_tick;
    logic half_tick;
    logic trail_full;
    snake_pkg::btn_vec_t buttons;
    snake_pkg::btn_vec_t btn_pulse;
    snake_pkg::mode_t mode;
    snake_pkg::seg_id_t cur_seg;

    assign buttons = {down, up, left, right};

    tick_gen #(
        .SAMPLE_DIV(SAMPLE_DIV),
        .SEC_DIV(SEC_DIV),
        .HALF_DIV(HALF_DIV)
    ) u_tick_gen (
        .clk(clk),
        .rst(rst),
        .sample_tick(sample_tick),
        .sec_tick(sec_tick),
        .half_tick(half_tick)
    );

    button_conditioner u_button_conditioner (
        .clk(clk),
        .rst(rst),
        .sample_tick(sample_tick),
        .buttons(buttons),
        .btn_pulse(btn_pulse)
    );

    // Down is the only button the controller listens to
    mode_fsm u_mode_fsm (
        .clk(clk),
        .rst(rst),
        .sec_tick(sec_tick),
        .half_tick(half_tick),
        .down_pulse(btn_pulse[3]),
        .trail_full(trail_full),
        .mode(mode),
        .init(init),
        .move(move),
        .fall(fall)
    );

    segment_walker u_segment_walker (
        .clk(clk),
        .rst(rst),
        .mode(mode),
        .btn_pulse(btn_pulse),
        .cur_seg(cur_seg),
        .heading(pos)
    );

    trail_display u_trail_display (
        .clk(clk),
        .rst(rst),
        .mode(mode),
        .cur_seg(cur_seg),
        .half_tick(half_tick),
        .display(display),
        .trail_full(trail_full)
    );

endmodule

// ==== testbench/segment_snake_sva.sv ====
module segment_snake_sva #(
    parameter int SEC_DIV = 200,
    parameter int HALF_DIV = 100
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                init,
    input  logic                move,
    input  logic                fall,
    input  snake_pkg::seg_vec_t display,
    input  snake_pkg::heading_t pos,
    input  snake_pkg::seg_id_t  cur_seg,
    input  snake_pkg::btn_vec_t btn_pulse,
    input  logic                trail_full
);

    localparam int WALK_LEN = 19;
    localparam snake_pkg::seg_vec_t G_ONLY = ~(snake_pkg::seg_vec_t'(1) << snake_pkg::SEG_G);

    // Row is segment, heading, button index (0 right, 1 left, 2 up), new segment, new heading
    localparam logic [11:0] WALK [WALK_LEN] = '{
        {snake_pkg::SEG_A, snake_pkg::HEAD_RIGHT, 2'd0, snake_pkg::SEG_B, snake_pkg::HEAD_DOWN},
        {snake_pkg::SEG_A, snake_pkg::HEAD_LEFT, 2'd1, snake_pkg::SEG_F, snake_pkg::HEAD_DOWN},
        {snake_pkg::SEG_B, snake_pkg::HEAD_UP, 2'd1, snake_pkg::SEG_A, snake_pkg::HEAD_LEFT},
        {snake_pkg::SEG_B, snake_pkg::HEAD_DOWN, 2'd0, snake_pkg::SEG_G, snake_pkg::HEAD_LEFT},
        {snake_pkg::SEG_B, snake_pkg::HEAD_DOWN, 2'd2, snake_pkg::SEG_C, snake_pkg::HEAD_DOWN},
        {snake_pkg::SEG_C, snake_pkg::HEAD_UP, 2'd1, snake_pkg::SEG_G, snake_pkg::HEAD_LEFT},
        {snake_pkg::SEG_C, snake_pkg::HEAD_UP, 2'd2, snake_pkg::SEG_B, snake_pkg::HEAD_UP},
        {snake_pkg::SEG_C, snake_pkg::HEAD_DOWN, 2'd0, snake_pkg::SEG_D, snake_pkg::HEAD_DOWN},
        {snake_pkg::SEG_D, snake_pkg::HEAD_RIGHT, 2'd1, snake_pkg::SEG_C, snake_pkg::HEAD_UP},
        {snake_pkg::SEG_D, snake_pkg::HEAD_LEFT, 2'd0, snake_pkg::SEG_E, snake_pkg::HEAD_UP},
        {snake_pkg::SEG_E, snake_pkg::HEAD_UP, 2'd0, snake_pkg::SEG_G, snake_pkg::HEAD_RIGHT},
        {snake_pkg::SEG_E, snake_pkg::HEAD_UP, 2'd2, snake_pkg::SEG_F, snake_pkg::HEAD_UP},
        {snake_pkg::SEG_E, snake_pkg::HEAD_DOWN, 2'd1, snake_pkg::SEG_D, snake_pkg::HEAD_RIGHT},
        {snake_pkg::SEG_F, snake_pkg::HEAD_UP, 2'd0, snake_pkg::SEG_A, snake_pkg::HEAD_RIGHT},
        {snake_pkg::SEG_F, snake_pkg::HEAD_DOWN, 2'd1, snake_pkg::SEG_G, snake_pkg::HEAD_RIGHT},
        {snake_pkg::SEG_G, snake_pkg::HEAD_RIGHT, 2'd1, snake_pkg::SEG_B, snake_pkg::HEAD_UP},
        {snake_pkg::SEG_G, snake_pkg::HEAD_RIGHT, 2'd0, snake_pkg::SEG_C, snake_pkg::HEAD_DOWN},
        {snake_pkg::SEG_G, snake_pkg::HEAD_LEFT, 2'd1, snake_pkg::SEG_E, snake_pkg::HEAD_DOWN},
        {snake_pkg::SEG_G, snake_pkg::HEAD_LEFT, 2'd0, snake_pkg::SEG_F, snake_pkg::HEAD_UP}
    };

    int fail_count = 0;
    int init_cycles;
    int full_cycles;
    logic [4:0] expect_walk;
    logic walk_armed;

    // First matching row wins and no match keeps the segment and heading
    function automatic logic [4:0] walk_ref(input logic [2:0] seg, input logic [1:0] head,
                                            input logic [2:0] btn);
        logic [4:0] result;
        logic found;
        result = {seg, head};
        found = 1'b0;
        for (int i = 0; i < WALK_LEN; i++) begin
            if (!found && WALK[i][11:9] == seg && WALK[i][8:7] == head &&
                btn[WALK[i][6:5]]) begin
                result = WALK[i][4:0];
                found = 1'b1;
            end
        end
        return result;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            init_cycles <= 0;
            full_cycles <= 0;
            expect_walk <= {snake_pkg::SEG_G, snake_pkg::HEAD_LEFT};
            walk_armed <= 1'b0;
        end else begin
            init_cycles <= init ? init_cycles + 1 : 0;
            full_cycles <= (fall && trail_full) ? full_cycles + 1 : 0;
            expect_walk <= walk_ref(cur_seg, pos, btn_pulse[2:0]);
            walk_armed <= !init;
        end
    end

    init_shows_g: assert property (@(posedge clk) disable iff (rst)
        $fell(rst) || (init && $past(init)) |->
            {init, display, pos} == {1'b1, G_ONLY, snake_pkg::HEAD_LEFT})
        else begin
            fail_count++;
            $error("Mismatch init_shows_g: expected %b, actual %b",
                   {1'b1, G_ONLY, snake_pkg::HEAD_LEFT}, $sampled({init, display, pos}));
        end

    modes_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot({init, move, fall}))
        else begin
            fail_count++;
            $error("Mismatch modes_onehot: expected one-hot, actual %b",
                   $sampled({init, move, fall}));
        end

    move_after_hold: assert property (@(posedge clk) disable iff (rst)
        $rose(move) |-> init_cycles >= 2 * SEC_DIV)
        else begin
            fail_count++;
            $error("Moving mode started after only %0d cycles in the initial mode",
                   $sampled(init_cycles));
        end

    move_holds: assert property (@(posedge clk) disable iff (rst)
        move && !btn_pulse[3] |=> move)
        else begin
            fail_count++;
            $error("Moving mode ended without a down press");
        end

    move_one_lit: assert property (@(posedge clk) disable iff (rst)
        move |-> $countones(~display) == 1)
        else begin
            fail_count++;
            $error("Mismatch move_one_lit: expected 1, actual %0d",
                   $countones(~$sampled(display)));
        end

    walk_follows_table: assert property (@(posedge clk) disable iff (rst)
        walk_armed |-> {cur_seg, pos} == expect_walk)
        else begin
            fail_count++;
            $error("Mismatch walk_follows_table: expected %b, actual %b",
                   $sampled(expect_walk), $sampled({cur_seg, pos}));
        end

    down_starts_fall: assert property (@(posedge clk) disable iff (rst)
        move && btn_pulse[3] |=> fall)
        else begin
            fail_count++;
            $error("Down press in the moving mode did not start the falling mode");
        end

    // Only the blinking head may go dark between two cycles
    trail_keeps_lit: assert property (@(posedge clk) disable iff (rst)
        $past(fall) && $past(fall, 2) |->
            (display & ~$past(display) & ~(snake_pkg::seg_vec_t'(1) << $past(cur_seg))) == '0)
        else begin
            fail_count++;
            $error("Trail lost a lit segment other than the current one");
        end

    init_after_full: assert property (@(posedge clk) disable iff (rst)
        fall && trail_full |-> full_cycles <= 2 * HALF_DIV)
        else begin
            fail_count++;
            $error("Full trail did not return to the initial mode in time");
        end

    init_needs_full: assert property (@(posedge clk) disable iff (rst)
        $rose(init) |-> $past(trail_full))
        else begin
            fail_count++;
            $error("Initial mode returned before the trail was full");
        end

endmodule

// ==== testbench/tb_segment_snake.sv ====
module tb_segment_snake;

    localparam int SAMPLE_DIV = 4;
    localparam int SEC_DIV = 200;
    localparam int HALF_DIV = 100;
    localparam int CLK_PERIOD = 20;
    localparam int NUM_PRESSES = 8;
    localparam int WATCHDOG_TIME =
        (NUM_PRESSES * 140 + 4 * SEC_DIV + 4 * HALF_DIV) * CLK_PERIOD;

    // Same bit order as the DUT's button vector
    localparam int BTN_RIGHT = 0;
    localparam int BTN_LEFT = 1;
    localparam int BTN_UP = 2;
    localparam int BTN_DOWN = 3;

    logic clk;
    logic rst;
    logic [3:0] btn_drive;
    logic [15:0] lfsr_q;
    snake_pkg::seg_vec_t display;
    logic init;
    logic move;
    logic fall;
    snake_pkg::heading_t pos;

    // Visits every segment once the falling mode starts
    int press_seq [NUM_PRESSES] = '{
        BTN_LEFT, BTN_DOWN, BTN_LEFT, BTN_LEFT, BTN_UP, BTN_LEFT, BTN_LEFT, BTN_LEFT
    };

    segment_snake #(
        .SAMPLE_DIV(SAMPLE_DIV),
        .SEC_DIV(SEC_DIV),
        .HALF_DIV(HALF_DIV)
    ) u_segment_snake (
        .clk(clk),
        .rst(rst),
        .right(btn_drive[BTN_RIGHT]),
        .left(btn_drive[BTN_LEFT]),
        .up(btn_drive[BTN_UP]),
        .down(btn_drive[BTN_DOWN]),
        .display(display),
        .init(init),
        .move(move),
        .fall(fall),
        .pos(pos)
    );

    bind segment_snake segment_snake_sva #(
        .SEC_DIV(SEC_DIV),
        .HALF_DIV(HALF_DIV)
    ) u_sva (
        .clk(clk),
        .rst(rst),
        .init(init),
        .move(move),
        .fall(fall),
        .display(display),
        .pos(pos),
        .cur_seg(cur_seg),
        .btn_pulse(btn_pulse),
        .trail_full(trail_full)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    // 40 to 70 cycles from five fresh LFSR bits
    task automatic random_cycles(output int cycles);
        int value;
        value = 0;
        for (int i = 0; i < 5; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            value = (value << 1) | lfsr_q[0];
        end
        cycles = 40 + (value % 31);
    endtask

    task automatic press_button(input int idx);
        int hold;
        int gap;
        random_cycles(hold);
        random_cycles(gap);
        btn_drive[idx] = 1'b1;
        repeat (hold) @(negedge clk);
        btn_drive[idx] = 1'b0;
        repeat (gap) @(negedge clk);
    endtask

    initial begin
        rst = 1'b1;
        btn_drive = '0;
        lfsr_q = 16'd63022;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        wait (move);
        @(negedge clk);
        foreach (press_seq[i]) begin
            press_button(press_seq[i]);
        end
        wait (init);
        repeat (4) @(negedge clk);
        $display("Assertion failures: %0d", u_segment_snake.u_sva.fail_count);
        if (u_segment_snake.u_sva.fail_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout: the game did not return to the initial mode in time");
        $display("Assertion failures: %0d", u_segment_snake.u_sva.fail_count);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== segment_snake.f ====
+incdir+source
source/snake_pkg.sv
source/tick_gen.sv
source/button_conditioner.sv
source/mode_fsm.sv
source/segment_walker.sv
source/trail_display.sv
source/segment_snake.sv
testbench/segment_snake_sva.sv
testbench/tb_segment_snake.sv

// ==== Bender.yml ====
package:
  name: segment_snake

sources:
  - include_dirs:
      - source
    files:
      - source/snake_pkg.sv
      - source/tick_gen.sv
      - source/button_conditioner.sv
      - source/mode_fsm.sv
      - source/segment_walker.sv
      - source/trail_display.sv
      - source/segment_snake.sv
  - target: test
    files:
      - testbench/segment_snake_sva.sv
      - testbench/tb_segment_snake.sv
